/* Bender.yml */
package:
  name: erx_addr_stage

sources:
  # Packages first, then the stages and the top level
  - files:
      - src/erx_pkg.sv
      - src/erx_cfg_pkg.sv
      - src/erx_remap.sv
      - src/erx_protect.sv
      - src/erx_dispatch.sv
      - src/erx_top.sv

  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_erx_top.sv

/* sim/erx_ref_model.svh */
// Reference rules for remap and window; the including module must import erx_pkg and erx_cfg_pkg
`ifndef ERX_REF_MODEL_SVH
`define ERX_REF_MODEL_SVH

// Smallest n with 2**n >= value
function automatic int unsigned ceil_log2(input int unsigned value);
  int unsigned bits;
  bits = 0;
  while ((1 << bits) < value) begin
    bits++;
  end
  return bits;
endfunction

// Destination address after the remap stage
function automatic logic [31:0] expected_addr(input logic [31:0] addr, input remap_cfg_t cfg);
  logic [11:0] row;
  logic [5:0]  col_id;
  int unsigned shift;
  logic [31:0] result;
  row    = addr[31:20];
  col_id = NODE_ID[5:0];
  shift  = ceil_log2((col_id == 6'd0) ? 1 : col_id);
  result = addr;
  if (row != NODE_ID && cfg.mode == REMAP_STATIC) begin
    for (int i = 0; i < 12; i++) begin
      if (cfg.sel[i]) begin
        result[20 + i] = cfg.pattern[i];
      end
    end
  end else if (row != NODE_ID && cfg.mode != REMAP_NONE) begin
    // Modes 10 and 11 are both dynamic
    result = addr - ({26'd0, col_id} << 20) + cfg.base - ({26'd0, addr[31:26]} << shift);
  end
  return result;
endfunction

// Original row must sit inside lo..hi, both ends included
function automatic bit row_in_window(input logic [31:0] addr, input window_cfg_t win);
  return (addr[31:20] >= win.lo) && (addr[31:20] <= win.hi);
endfunction

`endif

/* sim/tb_erx_top.sv */
// Directed tests; the sender never exceeds its RX_DEPTH credits and memory credits lag two cycles
`timescale 1ns/1ps

module tb_erx_top
  import erx_pkg::*;
  import erx_cfg_pkg::*;
();

  localparam int unsigned SEED           = 32'h6a2b65a3;
  localparam int          TEST_CYCLES    = 400;
  localparam int          TIMEOUT_CYCLES = 5 * TEST_CYCLES;

  logic                  clk;
  logic                  rst_n;
  logic                  rx_valid;
  emesh_packet_t         rx_packet;
  logic                  rx_credit;
  remap_cfg_t            remap_cfg;
  window_cfg_t           win_cfg;
  logic                  mem_valid;
  emesh_packet_t         mem_packet;
  logic                  mem_credit;
  logic                  drop_pulse;
  logic [DROP_CNT_W-1:0] drop_count;

  emesh_packet_t expected_q [$];
  int            sent_count;
  int            credits_returned;
  int            received_count;
  int            mem_returned;
  int            expected_drops;
  int            drops_seen;
  int            error_count;
  int            check_count;
  int            failed_tests;
  int            cycle_count;
  int            mem_owed;
  logic [1:0]    mem_delay;
  bit            mem_hold;

  `include "erx_ref_model.svh"

  erx_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_valid   (rx_valid),
    .rx_packet  (rx_packet),
    .rx_credit  (rx_credit),
    .remap_cfg  (remap_cfg),
    .win_cfg    (win_cfg),
    .mem_valid  (mem_valid),
    .mem_packet (mem_packet),
    .mem_credit (mem_credit),
    .drop_pulse (drop_pulse),
    .drop_count (drop_count)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic flag_error(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  // Scoreboard and input credit tracking
  always @(posedge clk) begin : monitor
    emesh_packet_t exp_pkt;
    if (rst_n && rx_credit) begin
      credits_returned++;
      check_count++;
      if (credits_returned > sent_count) begin
        flag_error($sformatf("Input credit returned with no packet outstanding at %0t", $time));
      end
    end
    if (rst_n && drop_pulse) begin
      drops_seen++;
    end
    if (rst_n && mem_valid) begin
      received_count++;
      check_count++;
      if (expected_q.size() == 0) begin
        flag_error($sformatf("Unexpected packet at mem_valid at %0t", $time));
      end else begin
        exp_pkt = expected_q.pop_front();
        if (mem_packet !== exp_pkt) begin
          flag_error($sformatf("mismatch: %0t packet addr %h ctrl %h, expected addr %h ctrl %h",
                               $time, mem_packet.addr, mem_packet.ctrl, exp_pkt.addr, exp_pkt.ctrl));
        end
      end
    end
  end

  // Memory returns a credit two cycles after each mem_valid unless held
  always @(posedge clk) begin : memory_model
    if (!rst_n) begin
      mem_delay = 2'b00;
      mem_owed  = 0;
      mem_credit <= #2 1'b0;
    end else begin
      mem_delay = {mem_delay[0], mem_valid};
      if (mem_delay[1]) begin
        mem_owed++;
      end
      if (!mem_hold && mem_owed > 0) begin
        mem_owed--;
        mem_returned++;
        mem_credit <= #2 1'b1;
      end else begin
        mem_credit <= #2 1'b0;
      end
    end
  end

  task automatic next_slot();
    @(posedge clk);
    #2;
  endtask

  function automatic emesh_packet_t make_packet(input logic [31:0] addr);
    emesh_packet_t pkt;
    pkt.rest = {$urandom, $urandom};
    pkt.addr = addr;
    pkt.ctrl = 8'($urandom_range(255));
    return pkt;
  endfunction

  // Random address whose row is not this node
  function automatic logic [31:0] remote_addr();
    logic [31:0] addr;
    addr = $urandom;
    if (addr[31:20] == NODE_ID) begin
      addr[31] = ~addr[31];
    end
    return addr;
  endfunction

  task automatic send_packet(input emesh_packet_t pkt);
    emesh_packet_t exp_pkt;
    while (sent_count - credits_returned >= RX_DEPTH) begin
      rx_valid = 1'b0;
      next_slot();
    end
    rx_valid  = 1'b1;
    rx_packet = pkt;
    sent_count++;
    if (row_in_window(pkt.addr, win_cfg)) begin
      exp_pkt      = pkt;
      exp_pkt.addr = expected_addr(pkt.addr, remap_cfg);
      expected_q.push_back(exp_pkt);
    end else begin
      expected_drops++;
    end
    next_slot();
    rx_valid = 1'b0;
  endtask

  // All packets out, all input and memory credits back
  task automatic wait_idle();
    while (expected_q.size() != 0 || sent_count != credits_returned ||
           mem_returned != received_count) begin
      next_slot();
    end
  endtask

  task automatic finish_test(input int num, input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: failed with %0d errors", num, name, error_count - errors_before);
    end
  endtask

  task automatic none_and_bypass();
    int errors_before;
    errors_before = error_count;
    remap_cfg = '{mode: REMAP_NONE, sel: 12'h0F0, pattern: 12'h5A5, base: 32'h0100_0000};
    win_cfg   = '{lo: 12'h100, hi: 12'h900};
    send_packet(make_packet(32'h1000_0040));
    send_packet(make_packet(32'h4A5F_FFFC));
    send_packet(make_packet(32'h9000_1234));
    send_packet(make_packet({NODE_ID, 20'h0ABCD}));
    // Own node ID must survive every mode
    remap_cfg.mode = REMAP_STATIC;
    send_packet(make_packet({NODE_ID, 20'h12345}));
    remap_cfg.mode = REMAP_DYNAMIC;
    send_packet(make_packet({NODE_ID, 20'h54321}));
    remap_cfg.mode = remap_mode_e'(2'b11);
    send_packet(make_packet({NODE_ID, 20'hFFFFF}));
    wait_idle();
    finish_test(1, "REMAP_NONE and ID bypass", errors_before);
  endtask

  task automatic static_remap();
    int          errors_before;
    logic [11:0] sels [3];
    logic [11:0] pats [3];
    errors_before = error_count;
    sels = '{12'h000, 12'hFFF, 12'hF0F};
    pats = '{12'hA5A, 12'h333, 12'h1C7};
    remap_cfg = '{mode: REMAP_STATIC, sel: 12'h000, pattern: 12'h000, base: 32'h0};
    win_cfg   = '{lo: 12'h000, hi: 12'hFFF};
    for (int k = 0; k < 3; k++) begin
      remap_cfg.sel     = sels[k];
      remap_cfg.pattern = pats[k];
      repeat (3) send_packet(make_packet(remote_addr()));
    end
    wait_idle();
    finish_test(2, "REMAP_STATIC", errors_before);
  endtask

  task automatic dynamic_remap();
    int errors_before;
    errors_before = error_count;
    remap_cfg = '{mode: REMAP_DYNAMIC, sel: 12'h0, pattern: 12'h0, base: 32'h1234_5000};
    win_cfg   = '{lo: 12'h000, hi: 12'hFFF};
    send_packet(make_packet(32'hFC30_0010));
    repeat (4) send_packet(make_packet(remote_addr()));
    remap_cfg.mode = remap_mode_e'(2'b11);
    remap_cfg.base = 32'h0008_0000;
    repeat (3) send_packet(make_packet(remote_addr()));
    wait_idle();
    finish_test(3, "dynamic remap", errors_before);
  endtask

  task automatic window_denial();
    int errors_before;
    int drops_before;
    int denied_before;
    int pulses_before;
    errors_before = error_count;
    drops_before  = int'(drop_count);
    denied_before = expected_drops;
    pulses_before = drops_seen;
    remap_cfg = '{mode: REMAP_NONE, sel: 12'h0, pattern: 12'h0, base: 32'h0};
    win_cfg   = '{lo: 12'h200, hi: 12'h5FF};
    send_packet(make_packet(32'h1FF0_0000));
    send_packet(make_packet(32'h2000_0004));
    send_packet(make_packet(32'h5FFF_FFF8));
    send_packet(make_packet(32'h6000_0000));
    send_packet(make_packet(32'h0000_0100));
    send_packet(make_packet(32'h3AB1_2340));
    send_packet(make_packet({NODE_ID, 20'h00010}));
    send_packet(make_packet(32'hFFF0_0000));
    wait_idle();
    check_count++;
    if (int'(drop_count) - drops_before != expected_drops - denied_before) begin
      flag_error($sformatf("mismatch: %0t drop_count rose by %0d, expected %0d", $time,
                           int'(drop_count) - drops_before, expected_drops - denied_before));
    end
    check_count++;
    if (drops_seen - pulses_before != expected_drops - denied_before) begin
      flag_error($sformatf("mismatch: %0t drop_pulse seen %0d times, expected %0d", $time,
                           drops_seen - pulses_before, expected_drops - denied_before));
    end
    finish_test(4, "window denial", errors_before);
  endtask

  task automatic credit_back_pressure();
    int errors_before;
    int received_before;
    errors_before   = error_count;
    received_before = received_count;
    remap_cfg = '{mode: REMAP_STATIC, sel: 12'h00F, pattern: 12'h003, base: 32'h0};
    win_cfg   = '{lo: 12'h000, hi: 12'hFFF};
    mem_hold  = 1'b1;
    // Fills the queue and uses the initial memory credits
    repeat (RX_DEPTH + MEM_CREDITS) send_packet(make_packet(remote_addr()));
    repeat (20) next_slot();
    check_count++;
    if (received_count - received_before > MEM_CREDITS) begin
      flag_error("More packets reached memory than its credits allow");
    end
    mem_hold = 1'b0;
    repeat (RX_DEPTH) send_packet(make_packet(remote_addr()));
    // Last packet out and its memory credit returned
    while (expected_q.size() != 0 || mem_returned != received_count) begin
      next_slot();
    end
    check_count++;
    if (RX_DEPTH - (sent_count - credits_returned) != RX_DEPTH) begin
      flag_error($sformatf("mismatch: %0t sender holds %0d credits, expected %0d", $time,
                           RX_DEPTH - (sent_count - credits_returned), RX_DEPTH));
    end
    finish_test(5, "credit back-pressure", errors_before);
  endtask

  initial begin
    void'($urandom(SEED));
    clk        = 1'b0;
    rst_n      = 1'b0;
    rx_valid   = 1'b0;
    rx_packet  = '0;
    mem_credit = 1'b0;
    mem_hold   = 1'b0;
    remap_cfg  = '0;
    win_cfg    = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_count++;
    if (mem_valid !== 1'b0 || rx_credit !== 1'b0 || drop_pulse !== 1'b0 || drop_count !== '0) begin
      flag_error($sformatf("mismatch: %0t outputs not idle after reset", $time));
    end
    none_and_bypass();
    static_remap();
    dynamic_remap();
    window_denial();
    credit_back_pressure();
    $display("Tests run: 5, tests failed: %0d, checks: %0d, errors: %0d",
             failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+sim
src/erx_pkg.sv
src/erx_cfg_pkg.sv
src/erx_remap.sv
src/erx_protect.sv
src/erx_dispatch.sv
src/erx_top.sv
sim/tb_erx_top.sv

/* src/erx_cfg_pkg.sv */
// Configuration is static; RX_DEPTH must be a power of two and erx_pkg must be compiled first
package erx_cfg_pkg;

  import erx_pkg::*;

  // This node's identity
  localparam logic [ID_W-1:0] NODE_ID     = 12'h808;
  localparam int unsigned     COL_ID      = NODE_ID[COL_W-1:0];
  localparam int unsigned     GROUP_SHIFT = $clog2((COL_ID < 1) ? 1 : COL_ID);

  // Column offset removed in dynamic remap
  localparam logic [ADDR_W-1:0] COL_OFFSET = ADDR_W'(COL_ID) << ROW_LSB;

  // Queue and credit sizing
  localparam int RX_DEPTH    = 4;
  localparam int MEM_CREDITS = 2;
  localparam int RX_PTR_W    = $clog2(RX_DEPTH);
  localparam int RX_CNT_W    = $clog2(RX_DEPTH + 1);
  localparam int MEM_CRED_W  = $clog2(MEM_CREDITS + 1);
  localparam int DROP_CNT_W  = 16;

  // Mode 2'b11 is treated as dynamic as well
  typedef enum logic [1:0] {
    REMAP_NONE    = 2'b00,
    REMAP_STATIC  = 2'b01,
    REMAP_DYNAMIC = 2'b10
  } remap_mode_e;

  typedef struct packed {
    remap_mode_e       mode;
    logic [ID_W-1:0]   sel;
    logic [ID_W-1:0]   pattern;
    logic [ADDR_W-1:0] base;
  } remap_cfg_t;

  // Inclusive range of allowed address rows
  typedef struct packed {
    logic [ID_W-1:0] lo;
    logic [ID_W-1:0] hi;
  } window_cfg_t;

endpackage

/* src/erx_dispatch.sv */
// Queue never overflows as long as the sender respects its RX_DEPTH input credits
`timescale 1ns/1ps

module erx_dispatch
  import erx_pkg::*;
  import erx_cfg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  stage_result_t         remap_res,
  input  stage_result_t         protect_res,
  input  logic                  mem_credit,
  output logic                  mem_valid,
  output emesh_packet_t         mem_packet,
  output logic                  rx_credit,
  output logic                  drop_pulse,
  output logic [DROP_CNT_W-1:0] drop_count
);

  emesh_packet_t         fifo_mem [RX_DEPTH];
  logic [RX_PTR_W-1:0]   wr_ptr;
  logic [RX_PTR_W-1:0]   rd_ptr;
  logic [RX_CNT_W-1:0]   fifo_count;
  logic [MEM_CRED_W-1:0] mem_cred;
  logic [RX_CNT_W-1:0]   credit_pend;
  logic [RX_CNT_W-1:0]   credit_total;
  logic                  credit_out;
  logic                  both_valid;
  logic                  wr_en;
  logic                  drop_en;
  logic                  send;
  logic                  mem_valid_q;
  emesh_packet_t         mem_packet_q;
  logic                  rx_credit_q;
  logic                  drop_pulse_q;
  logic [DROP_CNT_W-1:0] drop_count_q;

  // Packet from the remapper, verdict from the checker
  assign both_valid = remap_res.valid && protect_res.valid;
  assign wr_en      = both_valid && protect_res.allow;
  assign drop_en    = both_valid && !protect_res.allow;

  // Head leaves only when a memory credit is available
  assign send = (fifo_count != '0) && (mem_cred != '0);

  // A send and a drop on the same edge free two slots
  // The second credit waits in credit_pend for the next cycle
  assign credit_total = credit_pend + RX_CNT_W'(send) + RX_CNT_W'(drop_en);
  assign credit_out   = (credit_total != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_mem[wr_ptr] <= remap_res.packet;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      mem_packet_q <= fifo_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fifo_count   <= '0;
      mem_cred     <= MEM_CRED_W'(MEM_CREDITS);
      credit_pend  <= '0;
      mem_valid_q  <= 1'b0;
      rx_credit_q  <= 1'b0;
      drop_pulse_q <= 1'b0;
      drop_count_q <= '0;
    end else begin
      // Pointers wrap at RX_DEPTH
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_count <= fifo_count + RX_CNT_W'(wr_en) - RX_CNT_W'(send);
      mem_cred   <= mem_cred + MEM_CRED_W'(mem_credit) - MEM_CRED_W'(send);

      mem_valid_q  <= send;
      drop_pulse_q <= drop_en;
      if (drop_en) begin
        drop_count_q <= drop_count_q + 1'b1;
      end

      // One input credit per cycle at most
      rx_credit_q <= credit_out;
      credit_pend <= credit_total - RX_CNT_W'(credit_out);
    end
  end

  assign mem_valid  = mem_valid_q;
  assign mem_packet = mem_packet_q;
  assign rx_credit  = rx_credit_q;
  assign drop_pulse = drop_pulse_q;
  assign drop_count = drop_count_q;

endmodule

/* src/erx_pkg.sv */
// Packet layout assumes the 104-bit emesh format with the destination address at bits 39:8
package erx_pkg;

  // Packet field widths
  localparam int PACKET_W = 104;
  localparam int ADDR_W   = 32;
  localparam int CTRL_W   = 8;
  localparam int REST_W   = PACKET_W - ADDR_W - CTRL_W;

  // Row/column node ID sits in the top address bits
  localparam int ID_W     = 12;
  localparam int ROW_LSB  = ADDR_W - ID_W;

  // Column part of the node ID, also the width of the dynamic group field
  localparam int COL_W    = 6;

  // Data and source address travel in rest, untouched by this stage
  typedef struct packed {
    logic [REST_W-1:0] rest;
    logic [ADDR_W-1:0] addr;
    logic [CTRL_W-1:0] ctrl;
  } emesh_packet_t;

  // Registered output of one parallel stage
  typedef struct packed {
    logic          valid;
    emesh_packet_t packet;
    logic          allow;
  } stage_result_t;

endpackage

/* src/erx_protect.sv */
// One-cycle window check on the original address row; the packet field of the result is zero
`timescale 1ns/1ps

module erx_protect
  import erx_pkg::*;
  import erx_cfg_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  input  emesh_packet_t in_packet,
  input  window_cfg_t   win,
  output stage_result_t result
);

  logic [ID_W-1:0] in_row;
  logic            above_lo;
  logic            below_hi;
  logic            in_window;
  logic            valid_q;
  logic            allow_q;

  // Row of the address before any remap
  assign in_row = in_packet.addr[ADDR_W-1 -: ID_W];

  // Both bounds inclusive
  assign above_lo  = (in_row >= win.lo);
  assign below_hi  = (in_row <= win.hi);
  assign in_window = above_lo && below_hi;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // Allow is only meaningful alongside valid
  always_ff @(posedge clk) begin
    if (in_valid) begin
      allow_q <= in_window;
    end
  end

  assign result = '{valid: valid_q, packet: '0, allow: allow_q};

endmodule

/* src/erx_remap.sv */
// One-cycle remap stage; cfg is sampled with the packet and the allow output is always high
`timescale 1ns/1ps

module erx_remap
  import erx_pkg::*;
  import erx_cfg_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  input  emesh_packet_t in_packet,
  input  remap_cfg_t    cfg,
  output stage_result_t result
);

  logic [ID_W-1:0]   in_row;
  logic [ID_W-1:0]   static_row;
  logic [ADDR_W-1:0] static_addr;
  logic [ADDR_W-1:0] group_offset;
  logic [ADDR_W-1:0] dynamic_addr;
  logic [ADDR_W-1:0] remap_addr;
  logic              valid_q;
  emesh_packet_t     packet_q;

  assign in_row = in_packet.addr[ADDR_W-1 -: ID_W];

  // Pattern bits replace the row where sel is set
  assign static_row  = (cfg.sel & cfg.pattern) | (~cfg.sel & in_row);
  assign static_addr = {static_row, in_packet.addr[ROW_LSB-1:0]};

  // Group term taken from the top address bits
  assign group_offset = ADDR_W'(in_packet.addr[ADDR_W-1 -: COL_W]) << GROUP_SHIFT;

  assign dynamic_addr = in_packet.addr - COL_OFFSET + cfg.base - group_offset;

  // Packets already addressed to this node bypass every mode
  always_comb begin
    remap_addr = in_packet.addr;
    if (in_row != NODE_ID) begin
      case (cfg.mode)
        REMAP_NONE: begin
          remap_addr = in_packet.addr;
        end
        REMAP_STATIC: begin
          remap_addr = static_addr;
        end
        default: begin
          remap_addr = dynamic_addr;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // Only the address field is rewritten
  always_ff @(posedge clk) begin
    if (in_valid) begin
      packet_q.rest <= in_packet.rest;
      packet_q.addr <= remap_addr;
      packet_q.ctrl <= in_packet.ctrl;
    end
  end

  assign result = '{valid: valid_q, packet: packet_q, allow: 1'b1};

endmodule

/* src/erx_top.sv */
// Every rx_valid cycle is accepted, so the sender must hold a credit for each packet it sends
`timescale 1ns/1ps

module erx_top
  import erx_pkg::*;
  import erx_cfg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx_valid,
  input  emesh_packet_t         rx_packet,
  output logic                  rx_credit,
  input  remap_cfg_t            remap_cfg,
  input  window_cfg_t           win_cfg,
  output logic                  mem_valid,
  output emesh_packet_t         mem_packet,
  input  logic                  mem_credit,
  output logic                  drop_pulse,
  output logic [DROP_CNT_W-1:0] drop_count
);

  stage_result_t remap_res;
  stage_result_t protect_res;

  // Both stages see the same packet on the same edge
  erx_remap i_remap (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rx_valid),
    .in_packet (rx_packet),
    .cfg       (remap_cfg),
    .result    (remap_res)
  );

  erx_protect i_protect (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rx_valid),
    .in_packet (rx_packet),
    .win       (win_cfg),
    .result    (protect_res)
  );

  erx_dispatch i_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .remap_res   (remap_res),
    .protect_res (protect_res),
    .mem_credit  (mem_credit),
    .mem_valid   (mem_valid),
    .mem_packet  (mem_packet),
    .rx_credit   (rx_credit),
    .drop_pulse  (drop_pulse),
    .drop_count  (drop_count)
  );

endmodule
